//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_warp_issue
FILELIST = warp_issue.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- hw/inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   fetch_valid,
    input  warp_pipe_pkg::fetch_t  fetch,
    output logic                   fetch_ready,
    output logic                   dec_valid,
    output warp_pipe_pkg::decode_t dec,
    input  logic                   dec_ready
);

    warp_pipe_pkg::decode_t dec_n;
    logic [2:0]             funct3;
    logic                   alu_mod_i;
    logic [31:0]            imm_i;
    logic [31:0]            imm_s;
    logic [31:0]            imm_b;

    assign funct3    = fetch.instr[14:12];
    assign alu_mod_i = (funct3 == warp_isa_pkg::F3_SR) && fetch.instr[30];   // only srai
    assign imm_i     = {{20{fetch.instr[31]}}, fetch.instr[31:20]};
    assign imm_s     = {{20{fetch.instr[31]}}, fetch.instr[31:25], fetch.instr[11:7]};
    assign imm_b     = {{19{fetch.instr[31]}}, fetch.instr[31:25], fetch.instr[11:7], 1'b0};

    always_comb begin
        dec_n.wid     = fetch.wid;
        dec_n.tmask   = fetch.tmask;
        dec_n.pc      = fetch.pc;
        dec_n.rd      = fetch.instr[11:7];
        dec_n.rs1     = fetch.instr[19:15];
        dec_n.rs2     = fetch.instr[24:20];
        dec_n.ex_type = warp_isa_pkg::EX_ILLEGAL;   // unknown opcodes still flow on
        dec_n.op.alu  = warp_isa_pkg::ADD;
        dec_n.imm     = '0;
        dec_n.use_imm = 1'b0;
        dec_n.wb      = 1'b0;
        case (fetch.instr[6:0])
            warp_isa_pkg::OP_ALU_R: begin
                dec_n.ex_type = warp_isa_pkg::EX_ALU;
                dec_n.op.alu  = warp_isa_pkg::alu_op_e'({fetch.instr[30], funct3});
                dec_n.wb      = 1'b1;
            end
            warp_isa_pkg::OP_ALU_I: begin
                dec_n.ex_type = warp_isa_pkg::EX_ALU;
                dec_n.op.alu  = warp_isa_pkg::alu_op_e'({alu_mod_i, funct3});
                dec_n.imm     = imm_i;
                dec_n.use_imm = 1'b1;
                dec_n.wb      = 1'b1;
            end
            warp_isa_pkg::OP_LOAD: begin
                dec_n.ex_type = warp_isa_pkg::EX_LSU;
                dec_n.op.mem  = warp_isa_pkg::mem_op_e'({1'b0, funct3});
                dec_n.imm     = imm_i;
                dec_n.use_imm = 1'b1;
                dec_n.wb      = 1'b1;
            end
            warp_isa_pkg::OP_STORE: begin
                dec_n.ex_type = warp_isa_pkg::EX_LSU;
                dec_n.op.mem  = warp_isa_pkg::mem_op_e'({1'b1, funct3});
                dec_n.imm     = imm_s;
                dec_n.use_imm = 1'b1;
            end
            warp_isa_pkg::OP_BRANCH: begin
                dec_n.ex_type = warp_isa_pkg::EX_BR;
                dec_n.op.alu  = warp_isa_pkg::alu_op_e'({1'b0, funct3});   // condition in low bits
                dec_n.imm     = imm_b;
            end
            default: begin
            end
        endcase
    end

    // single output register, refilled when empty or drained this cycle
    assign fetch_ready = !dec_valid || dec_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else if (fetch_ready) begin
            dec_valid <= fetch_valid;
        end
        if (fetch_valid && fetch_ready) begin
            dec <= dec_n;
        end
    end

endmodule

//--- hw/instr_buffer.sv
`timescale 1ns/1ns

module instr_buffer #(
    parameter int NUM_WARPS = 4,
    parameter int IBUF_SIZE = 4
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            freeze,
    input  logic                            enq_valid,
    input  warp_pipe_pkg::decode_t          enq,
    output logic                            enq_ready,
    output logic                            deq_valid,
    output warp_pipe_pkg::decode_t          deq,
    input  logic                            deq_ready,
    output logic [warp_pipe_pkg::WID_W-1:0] next_wid
);

    localparam int WID_W = warp_pipe_pkg::WID_W;
    localparam int CNTW  = $clog2(IBUF_SIZE + 1);
    localparam int NWW   = $clog2(NUM_WARPS + 1);

    logic [NUM_WARPS-1:0][CNTW-1:0] q_cnt;
    logic [NUM_WARPS-1:0][CNTW-1:0] w_cnt;     // queued plus the presented one
    warp_pipe_pkg::decode_t         q_data [NUM_WARPS];
    logic [NUM_WARPS-1:0]           cand;      // warps with a queued entry
    logic [NUM_WARPS-1:0]           cur_oh;
    logic [NUM_WARPS-1:0]           enq_oh;
    logic [NUM_WARPS-1:0]           push;
    logic [NUM_WARPS-1:0]           pop;
    logic [NUM_WARPS-1:0]           sched_r;   // warps still due in this pass
    logic [NUM_WARPS-1:0]           sched_n;
    logic [NUM_WARPS-1:0]           eligible;
    logic [NUM_WARPS-1:0]           pick_oh;
    logic [NUM_WARPS-1:0]           active_r;
    logic [NUM_WARPS-1:0]           active_n;
    logic [NWW-1:0]                 num_active_r;
    logic                           warp_added;
    logic                           warp_removed;
    logic                           deq_valid_n;
    warp_pipe_pkg::decode_t         deq_n;
    logic                           enq_fire;
    logic                           load_en;
    logic                           stay;
    logic                           bypass;

    assign enq_fire = enq_valid && enq_ready;
    assign load_en  = !deq_valid || deq_ready;   // output slot free next cycle

    for (genvar w = 0; w < NUM_WARPS; w++) begin : g_warp
        assign cur_oh[w] = deq_valid && (deq.wid == WID_W'(w));
        assign enq_oh[w] = (enq.wid == WID_W'(w));
        assign cand[w]   = (q_cnt[w] != '0);
        assign w_cnt[w]  = q_cnt[w] + CNTW'(cur_oh[w]);
        assign push[w]   = enq_fire && enq_oh[w] && !bypass;

        warp_queue #(
            .DEPTH (IBUF_SIZE),
            .DATAW ($bits(warp_pipe_pkg::decode_t))
        ) u_queue (
            .clk      (clk),
            .reset    (reset),
            .push     (push[w]),
            .pop      (pop[w]),
            .data_in  (enq),
            .data_out (q_data[w]),
            .count    (q_cnt[w])
        );
    end

    always_comb begin
        enq_ready = 1'b0;
        for (int i = 0; i < NUM_WARPS; i++) begin
            if (enq_oh[i]) enq_ready = (w_cnt[i] < CNTW'(IBUF_SIZE));
        end
    end

    // keep the current warp while it is alone or frozen and has more queued
    assign stay = deq_valid && (freeze || (num_active_r == NWW'(1))) && |(cand & cur_oh);

    always_comb begin
        eligible = sched_r & cand;
        if (eligible == '0) begin
            eligible = cand;   // start a new pass from the valid warps
        end
        pick_oh = '0;
        for (int i = NUM_WARPS - 1; i >= 0; i--) begin
            if (eligible[i]) pick_oh = NUM_WARPS'(1) << i;   // lowest id wins
        end
        deq_valid_n = deq_valid;
        deq_n       = deq;
        pop         = '0;
        bypass      = 1'b0;
        if (load_en) begin
            if (stay || (cand != '0)) begin
                pop         = stay ? cur_oh : pick_oh;
                deq_valid_n = 1'b1;
                for (int i = 0; i < NUM_WARPS; i++) begin
                    if (pop[i]) deq_n = q_data[i];
                end
            end else begin
                bypass      = enq_fire;   // nothing queued, present the new record directly
                deq_valid_n = enq_fire;
                deq_n       = enq;
            end
        end
        sched_n = sched_r;
        if (load_en && deq_valid_n) begin
            for (int i = 0; i < NUM_WARPS; i++) begin
                sched_n[i] = (WID_W'(i) > deq_n.wid);
            end
        end
    end

    always_comb begin
        active_n = active_r;
        for (int i = 0; i < NUM_WARPS; i++) begin
            if (deq_valid && deq_ready && cur_oh[i] && (w_cnt[i] == CNTW'(1))) begin
                active_n[i] = 1'b0;
            end
            if (enq_fire && enq_oh[i]) active_n[i] = 1'b1;
        end
    end

    assign warp_added   = |(active_n & ~active_r);
    assign warp_removed = |(active_r & ~active_n);

    always_ff @(posedge clk) begin
        if (reset) begin
            deq_valid    <= 1'b0;
            sched_r      <= '0;
            active_r     <= '0;
            num_active_r <= '0;
        end else begin
            deq_valid <= deq_valid_n;
            sched_r   <= sched_n;
            active_r  <= active_n;
            if (warp_added && !warp_removed) begin
                num_active_r <= num_active_r + 1'b1;
            end else if (warp_removed && !warp_added) begin
                num_active_r <= num_active_r - 1'b1;
            end
        end
        deq <= deq_n;
    end

    assign next_wid = deq_n.wid;

endmodule

//--- hw/warp_isa_pkg.sv
package warp_isa_pkg;

    // major opcodes, anything else decodes as illegal
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_ALU_I  = 7'b0010011,
        OP_STORE  = 7'b0100011,
        OP_ALU_R  = 7'b0110011,
        OP_BRANCH = 7'b1100011
    } opcode_e;

    // funct3 codes
    localparam logic [2:0] F3_ADD = 3'b000;   // add/sub share it, bit 30 picks
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SR  = 3'b101;   // srl/sra, bit 30 picks
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_B   = 3'b000;   // memory access sizes
    localparam logic [2:0] F3_H   = 3'b001;
    localparam logic [2:0] F3_W   = 3'b010;

    typedef enum logic [1:0] {
        EX_ALU,
        EX_LSU,
        EX_BR,
        EX_ILLEGAL
    } ex_type_e;

    // {bit 30 modifier, funct3}
    typedef enum logic [3:0] {
        ADD = {1'b0, F3_ADD},
        SUB = {1'b1, F3_ADD},
        SLL = {1'b0, F3_SLL},
        SLT = {1'b0, F3_SLT},
        XOR = {1'b0, F3_XOR},
        SRL = {1'b0, F3_SR},
        SRA = {1'b1, F3_SR},
        OR  = {1'b0, F3_OR},
        AND = {1'b0, F3_AND}
    } alu_op_e;

    // {store, funct3}
    typedef enum logic [3:0] {
        LB = {1'b0, F3_B},
        LH = {1'b0, F3_H},
        LW = {1'b0, F3_W},
        SB = {1'b1, F3_B},
        SH = {1'b1, F3_H},
        SW = {1'b1, F3_W}
    } mem_op_e;

    // alu view for EX_ALU and EX_BR, mem view for EX_LSU
    typedef union packed {
        alu_op_e alu;
        mem_op_e mem;
    } op_u;

endpackage

//--- hw/warp_issue_top.sv
`timescale 1ns/1ns

module warp_issue_top #(
    parameter int NUM_WARPS = 4,
    parameter int IBUF_SIZE = 4
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            fetch_valid,
    input  warp_pipe_pkg::fetch_t           fetch,
    output logic                            fetch_ready,
    input  logic                            freeze,
    output logic                            issue_valid,
    output warp_pipe_pkg::decode_t          issue,
    input  logic                            issue_ready,
    output logic [warp_pipe_pkg::WID_W-1:0] next_wid
);

    logic                   dec_valid;
    logic                   dec_ready;
    warp_pipe_pkg::decode_t dec;

    inst_decoder u_decoder (
        .clk         (clk),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch       (fetch),
        .fetch_ready (fetch_ready),
        .dec_valid   (dec_valid),
        .dec         (dec),
        .dec_ready   (dec_ready)
    );

    instr_buffer #(
        .NUM_WARPS (NUM_WARPS),
        .IBUF_SIZE (IBUF_SIZE)
    ) u_ibuf (
        .clk       (clk),
        .reset     (reset),
        .freeze    (freeze),
        .enq_valid (dec_valid),
        .enq       (dec),
        .enq_ready (dec_ready),
        .deq_valid (issue_valid),
        .deq       (issue),
        .deq_ready (issue_ready),
        .next_wid  (next_wid)
    );

endmodule

//--- hw/warp_pipe_pkg.sv
package warp_pipe_pkg;

    // warp id width stays 3 for any NUM_WARPS, so at most 8 warps
    localparam int WID_W   = 3;
    localparam int TMASK_W = 4;   // one bit per thread

    // record handed over by fetch
    typedef struct packed {
        logic [WID_W-1:0]   wid;
        logic [TMASK_W-1:0] tmask;
        logic [31:0]        pc;
        logic [31:0]        instr;
    } fetch_t;

    // record produced by the decoder and held in the instruction buffer
    typedef struct packed {
        logic [WID_W-1:0]       wid;
        logic [TMASK_W-1:0]     tmask;
        logic [31:0]            pc;
        warp_isa_pkg::ex_type_e ex_type;
        warp_isa_pkg::op_u      op;        // meaning depends on ex_type
        logic [4:0]             rd;
        logic [4:0]             rs1;
        logic [4:0]             rs2;
        logic [31:0]            imm;       // sign extended
        logic                   use_imm;   // second operand from imm
        logic                   wb;        // writes rd
    } decode_t;

endpackage

//--- hw/warp_queue.sv
`timescale 1ns/1ns

module warp_queue #(
    parameter int DEPTH = 4,
    parameter int DATAW = 32
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       push,
    input  logic                       pop,
    input  logic [DATAW-1:0]           data_in,
    output logic [DATAW-1:0]           data_out,
    output logic [$clog2(DEPTH+1)-1:0] count
);

    localparam int ADDRW = $clog2(DEPTH);
    localparam int CNTW  = $clog2(DEPTH + 1);

    logic [DATAW-1:0] mem [DEPTH];
    logic [ADDRW-1:0] rd_ptr;
    logic [ADDRW-1:0] wr_ptr;
    logic [ADDRW-1:0] rd_next;
    logic [ADDRW-1:0] wr_next;
    logic             head_from_in;
    logic             head_from_mem;

    // wrap explicitly so DEPTH need not be a power of two
    assign rd_next = (rd_ptr == ADDRW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
    assign wr_next = (wr_ptr == ADDRW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;

    // head slot takes the new word when the queue is, or is about to be, empty
    assign head_from_in  = push && ((count == '0) || ((count == CNTW'(1)) && pop));
    assign head_from_mem = pop && (count > CNTW'(1));

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_next;
            end
            if (pop) begin
                rd_ptr <= rd_next;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
        if (push) begin
            mem[wr_ptr] <= data_in;
        end
        if (head_from_in) begin
            data_out <= data_in;
        end else if (head_from_mem) begin
            data_out <= mem[rd_next];   // entry behind the head is already stored
        end
    end

endmodule

//--- test/tb_warp_issue.sv
`timescale 1ns/1ns

module tb_warp_issue;

    localparam int NUM_WARPS = 4;
    localparam int IBUF_SIZE = 4;

    logic                            clk = 1'b0;
    logic                            reset;
    logic                            fetch_valid;
    warp_pipe_pkg::fetch_t           fetch;
    logic                            fetch_ready;
    logic                            freeze;
    logic                            issue_valid;
    warp_pipe_pkg::decode_t          issue;
    logic                            issue_ready;
    logic [warp_pipe_pkg::WID_W-1:0] next_wid;

    logic [31:0]            seed = 32'h416d_58d3;
    warp_pipe_pkg::decode_t mq [NUM_WARPS][$];      // outstanding records per warp
    logic                   prev_valid;
    logic [2:0]             prev_next;
    logic                   fair_on;
    logic                   fz_active;
    logic [2:0]             frozen;
    logic [NUM_WARPS-1:0]   miss [NUM_WARPS];       // warps still owed an issue
    logic [NUM_WARPS-1:0]   busy;
    warp_pipe_pkg::decode_t snap;
    logic                   have_snap;
    logic [31:0]            r;
    int                     n;
    int                     t;

    warp_issue_top #(
        .NUM_WARPS (NUM_WARPS),
        .IBUF_SIZE (IBUF_SIZE)
    ) UUT (
        .clk         (clk),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch       (fetch),
        .fetch_ready (fetch_ready),
        .freeze      (freeze),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .next_wid    (next_wid)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {seed[15:0], seed[31:16]};   // high state bits are the better ones
    endfunction

    function automatic warp_pipe_pkg::fetch_t random_fetch(logic [2:0] wid);
        warp_pipe_pkg::fetch_t f;
        logic [31:0]           sel;
        sel     = lcg();
        f.wid   = wid;
        f.tmask = sel[3:0];
        f.pc    = lcg() & 32'hffff_fffc;
        f.instr = lcg();
        case (sel[6:4])
            3'd0, 3'd5: f.instr[6:0] = warp_isa_pkg::OP_ALU_R;
            3'd1, 3'd6: f.instr[6:0] = warp_isa_pkg::OP_ALU_I;
            3'd2:       f.instr[6:0] = warp_isa_pkg::OP_LOAD;
            3'd3:       f.instr[6:0] = warp_isa_pkg::OP_STORE;
            3'd4:       f.instr[6:0] = warp_isa_pkg::OP_BRANCH;
            default: begin
            end
        endcase
        return f;
    endfunction

    function automatic warp_pipe_pkg::decode_t model_decode(warp_pipe_pkg::fetch_t f);
        warp_pipe_pkg::decode_t d;
        logic [2:0]             f3;
        logic [31:0]            i_imm;
        logic [31:0]            s_imm;
        f3    = f.instr[14:12];
        i_imm = 32'($signed(f.instr[31:20]));
        s_imm = 32'($signed({f.instr[31:25], f.instr[11:7]}));
        d         = '0;   // illegal: no writeback, op bits zero
        d.wid     = f.wid;
        d.tmask   = f.tmask;
        d.pc      = f.pc;
        d.rd      = f.instr[11:7];
        d.rs1     = f.instr[19:15];
        d.rs2     = f.instr[24:20];
        d.ex_type = warp_isa_pkg::EX_ILLEGAL;
        case (f.instr[6:0])
            warp_isa_pkg::OP_ALU_R: begin
                d.ex_type = warp_isa_pkg::EX_ALU;
                d.op.alu  = warp_isa_pkg::alu_op_e'({f.instr[30], f3});
                d.wb      = 1'b1;
            end
            warp_isa_pkg::OP_ALU_I: begin
                d.ex_type = warp_isa_pkg::EX_ALU;
                d.op.alu  = warp_isa_pkg::alu_op_e'({f.instr[30] && (f3 == 3'b101), f3});
                d.imm     = i_imm;
                d.use_imm = 1'b1;
                d.wb      = 1'b1;
            end
            warp_isa_pkg::OP_LOAD: begin
                d.ex_type = warp_isa_pkg::EX_LSU;
                d.op.mem  = warp_isa_pkg::mem_op_e'({1'b0, f3});
                d.imm     = i_imm;
                d.use_imm = 1'b1;
                d.wb      = 1'b1;
            end
            warp_isa_pkg::OP_STORE: begin
                d.ex_type = warp_isa_pkg::EX_LSU;
                d.op.mem  = warp_isa_pkg::mem_op_e'({1'b1, f3});
                d.imm     = s_imm;
                d.use_imm = 1'b1;
            end
            warp_isa_pkg::OP_BRANCH: begin
                d.ex_type = warp_isa_pkg::EX_BR;
                d.op.alu  = warp_isa_pkg::alu_op_e'({1'b0, f3});
                d.imm     = s_imm << 1;
            end
            default: begin
            end
        endcase
        return d;
    endfunction

    task automatic die(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic value_error(input string msg);
        die($sformatf("[ERROR] %0t: %s", $time, msg));
    endtask

    task automatic check_decode(input warp_pipe_pkg::decode_t got,
                                input warp_pipe_pkg::decode_t exp);
        string fld;
        fld = "";
        if (got.wid != exp.wid) fld = "wid";
        else if (got.tmask != exp.tmask) fld = "tmask";
        else if (got.pc != exp.pc) fld = "pc";
        else if (got.ex_type != exp.ex_type) fld = "ex_type";
        else if (got.op != exp.op) fld = "op";
        else if (got.rd != exp.rd) fld = "rd";
        else if (got.rs1 != exp.rs1) fld = "rs1";
        else if (got.rs2 != exp.rs2) fld = "rs2";
        else if (got.imm != exp.imm) fld = "imm";
        else if (got.use_imm != exp.use_imm) fld = "use_imm";
        else if (got.wb != exp.wb) fld = "wb";
        if (fld != "") begin
            value_error($sformatf("record field %s differs, got %h expected %h", fld, got, exp));
        end
    endtask

    task automatic check_wid(input logic [warp_pipe_pkg::WID_W-1:0] got,
                             input logic [warp_pipe_pkg::WID_W-1:0] exp,
                             input string what);
        if (got != exp) value_error($sformatf("%s: got warp %0d expected %0d", what, got, exp));
    endtask

    function automatic int outstanding();
        int sum;
        sum = 0;
        for (int i = 0; i < NUM_WARPS; i++) sum += mq[i].size();
        return sum;
    endfunction

    // reference model and checks, sampled on the edge before DUT updates
    always @(posedge clk) begin
        if (reset) begin
            prev_valid = 1'b0;
        end else begin
            if (fetch_valid && fetch_ready) mq[fetch.wid].push_back(model_decode(fetch));
            if (issue_valid && prev_valid) check_wid(issue.wid, prev_next, "next_wid");
            for (int i = 0; i < NUM_WARPS; i++) busy[i] = (mq[i].size() >= 2);
            for (int i = 0; i < NUM_WARPS; i++) miss[i] = miss[i] & busy;
            if (issue_valid && issue_ready) begin
                if (mq[issue.wid].size() == 0) begin
                    die($sformatf("warp %0d issued a record that was never fetched", issue.wid));
                end else begin
                    check_decode(issue, mq[issue.wid].pop_front());
                end
                if (fair_on) begin
                    if (miss[issue.wid] != '0) begin
                        value_error($sformatf("warp %0d issued again before warps %b",
                                              issue.wid, miss[issue.wid]));
                    end
                    for (int i = 0; i < NUM_WARPS; i++) miss[i][issue.wid] = 1'b0;
                    miss[issue.wid] = busy & ~(NUM_WARPS'(1) << issue.wid);
                end
                if (fz_active) begin
                    check_wid(issue.wid, frozen, "issue under freeze");
                    if (mq[frozen].size() == 0) fz_active = 1'b0;
                end
            end
            prev_valid = issue_valid;
            prev_next  = next_wid;
        end
    end

    task automatic send(input logic [2:0] wid);
        int w;
        w = 0;
        @(posedge clk);
        fetch_valid <= 1'b1;
        fetch       <= random_fetch(wid);
        do begin
            @(negedge clk);
            w++;
        end while (!fetch_ready && w < 50);
        if (!fetch_ready) die("fetch was never accepted");
        @(posedge clk);
        fetch_valid <= 1'b0;
    endtask

    task automatic stop_fetch();
        int w;
        w = 0;
        @(posedge clk);
        issue_ready <= 1'b1;
        @(negedge clk);
        while (fetch_valid && !fetch_ready && w < 100) begin
            @(negedge clk);
            w++;
        end
        if (fetch_valid && !fetch_ready) die("pending fetch stuck while stopping traffic");
        @(posedge clk);
        fetch_valid <= 1'b0;
    endtask

    task automatic drain();
        int w;
        w = 0;
        @(posedge clk);
        issue_ready <= 1'b1;
        freeze      <= 1'b0;
        do begin
            @(negedge clk);
            w++;
        end while ((issue_valid || outstanding() != 0) && w < 300);
        if (issue_valid || outstanding() != 0) die("drain timed out with records left");
    endtask

    task automatic fill();
        @(posedge clk);
        issue_ready <= 1'b0;
        freeze      <= 1'b0;
        for (int k = 0; k < 3 * NUM_WARPS; k++) send(3'(k % NUM_WARPS));
    endtask

    initial begin
        reset       = 1'b1;
        fetch_valid = 1'b0;
        fetch       = '0;
        freeze      = 1'b0;
        issue_ready = 1'b0;
        fair_on     = 1'b0;
        fz_active   = 1'b0;
        frozen      = '0;
        for (int i = 0; i < NUM_WARPS; i++) miss[i] = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        if (!fetch_ready || issue_valid) die("ports not idle after reset");

        // random traffic with random stalls and freeze
        repeat (3000) begin
            @(posedge clk);
            r = lcg();
            if (!fetch_valid || fetch_ready) begin
                fetch_valid <= (r[1:0] != 2'd0);
                fetch       <= random_fetch(3'(r[3:2]));
            end
            issue_ready <= (r[9:8] != 2'd0);
            freeze      <= (r[14:12] == 3'd0);
        end
        stop_fetch();
        drain();

        // back-pressure on warp 0
        @(posedge clk);
        issue_ready <= 1'b0;
        fetch_valid <= 1'b1;
        fetch       <= random_fetch(3'd0);
        n           = 0;
        have_snap   = 1'b0;
        repeat (40) begin
            @(negedge clk);
            if (fetch_ready) n++;
            if (issue_valid && !have_snap) begin
                snap      = issue;
                have_snap = 1'b1;
            end else if (issue_valid) begin
                check_decode(issue, snap);
            end else if (have_snap) begin
                die("issue_valid dropped while issue_ready was low");
            end
            @(posedge clk);
            if (fetch_ready) fetch <= random_fetch(3'd0);
        end
        if (n != IBUF_SIZE + 1) begin
            value_error($sformatf("%0d fetches accepted under back-pressure, expected %0d",
                                  n, IBUF_SIZE + 1));
        end
        stop_fetch();
        drain();

        // round-robin fairness while draining several warps
        fill();
        @(negedge clk);
        for (int i = 0; i < NUM_WARPS; i++) miss[i] = '0;
        fair_on = 1'b1;
        drain();
        @(negedge clk);
        fair_on = 1'b0;

        // freeze holds the presented warp until it empties
        fill();
        @(posedge clk);
        freeze <= 1'b1;
        @(negedge clk);
        if (!issue_valid) die("no record presented before the freeze test");
        frozen    = issue.wid;
        fz_active = 1'b1;
        @(posedge clk);
        issue_ready <= 1'b1;
        t = 0;
        while (fz_active && t < 200) begin
            @(negedge clk);
            t++;
        end
        if (fz_active) die("frozen warp did not drain in time");
        drain();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- warp_issue.f
hw/warp_isa_pkg.sv
hw/warp_pipe_pkg.sv
hw/inst_decoder.sv
hw/warp_queue.sv
hw/instr_buffer.sv
hw/warp_issue_top.sv
test/tb_warp_issue.sv
